// File: mem_access_controller.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/mem_ctrl_pkg.sv
hw/word_ram.sv
hw/read_aligner.sv
hw/write_merger.sv
hw/access_sequencer.sv
hw/mem_access_controller.sv
sim/mem_access_controller_asserts.sv
sim/mem_access_controller_tb.sv

// File: sim/mem_access_controller_tb.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module mem_access_controller_tb;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 16;
    localparam int MODEL_BYTES  = `MAC_RAM_DEPTH * `MAC_WORD_BYTES;
    // Words 0..16 cover unaligned accesses at the top of the first 16 words
    localparam int FILL_WORDS   = 17;
    localparam int RANDOM_OPS   = 200;
    // Cycle budget for one request
    localparam int OP_LIMIT     = 40;

    // Planned requests per test
    localparam int FILL_OPS      = FILL_WORDS + 1;
    localparam int ALIGNED_OPS   = 8 * 2;
    localparam int PARTIAL_OPS   = 6 * 2;
    localparam int UNALIGNED_OPS = 3 * 2 * 6 + 2;
    localparam int PLANNED_OPS   = FILL_OPS + ALIGNED_OPS + PARTIAL_OPS + UNALIGNED_OPS
                                   + RANDOM_OPS;
    localparam longint WATCHDOG_NS = longint'(RESET_CYCLES + OP_LIMIT * PLANNED_OPS)
                                     * 2 * CLK_HALF;

    logic                  clk;
    logic                  reset;
    logic                  cmd_start;
    mem_ctrl_pkg::mem_op_e op;
    mem_bus_pkg::addr_t    addr;
    mem_bus_pkg::word_t    wdata;
    mem_bus_pkg::mask_t    wmask;
    logic                  cmd_ready;
    mem_bus_pkg::word_t    rdata;
    logic                  rdata_valid;

    // Expected RAM contents, one entry per byte address
    logic [7:0] model [MODEL_BYTES];

    int rnd_seed;

    mem_access_controller i_mem_access_controller (
        .clk         (clk),
        .reset       (reset),
        .cmd_start   (cmd_start),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    bind access_sequencer mem_access_controller_asserts i_asserts (
        .clk         (clk),
        .reset       (reset),
        .cmd_ready   (cmd_ready),
        .rdata_valid (rdata_valid),
        .ram_start   (ram_start),
        .ram_ready   (ram_ready),
        .state       (state)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_word(input string test, input mem_bus_pkg::word_t expected,
                                input mem_bus_pkg::word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error %s: expected %h, actual %h", test, expected, actual));
        end
    endtask

    task automatic compare_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error %s: expected %b, actual %b", test, expected, actual));
        end
    endtask

    // Little-endian byte update, bit-level mask
    function automatic void model_write(input mem_bus_pkg::addr_t a,
                                        input mem_bus_pkg::word_t d,
                                        input mem_bus_pkg::mask_t m);
        int idx;
        for (int i = 0; i < `MAC_WORD_BYTES; i++) begin
            idx = int'((a + i) % MODEL_BYTES);
            model[idx] = (model[idx] & ~m[8*i +: 8]) | (d[8*i +: 8] & m[8*i +: 8]);
        end
    endfunction

    function automatic mem_bus_pkg::word_t model_read(input mem_bus_pkg::addr_t a);
        mem_bus_pkg::word_t w;
        for (int i = 0; i < `MAC_WORD_BYTES; i++) begin
            w[8*i +: 8] = model[int'((a + i) % MODEL_BYTES)];
        end
        return w;
    endfunction

    // Odd multiplier keeps every address distinct
    function automatic mem_bus_pkg::word_t fill_pattern(input mem_bus_pkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic mem_bus_pkg::mask_t byte_mask(input logic [3:0] en);
        return {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
    endfunction

    // Called at the drive point after a clock edge
    task automatic wait_ready(input string test);
        int cycles;
        cycles = 0;
        while (cmd_ready !== 1'b1) begin
            if (cycles >= OP_LIMIT) begin
                stop_run($sformatf("%s: controller never returned to ready", test));
            end
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
    endtask

    task automatic do_write(input string test, input mem_bus_pkg::addr_t a,
                            input mem_bus_pkg::word_t d, input mem_bus_pkg::mask_t m);
        wait_ready(test);
        cmd_start = 1'b1;
        op        = mem_ctrl_pkg::OP_WRITE;
        addr      = a;
        wdata     = d;
        wmask     = m;
        @(posedge clk);
        #DRIVE_DLY;
        cmd_start = 1'b0;
        model_write(a, d, m);
        // Write is over once the controller takes requests again
        wait_ready(test);
    endtask

    task automatic do_read(input string test, input mem_bus_pkg::addr_t a);
        mem_bus_pkg::word_t expected;
        int                 cycles;
        expected = model_read(a);
        wait_ready(test);
        cmd_start = 1'b1;
        op        = mem_ctrl_pkg::OP_READ;
        addr      = a;
        @(posedge clk);
        #DRIVE_DLY;
        cmd_start = 1'b0;
        cycles    = 0;
        while (rdata_valid !== 1'b1) begin
            if (cycles >= OP_LIMIT) begin
                stop_run($sformatf("%s: no read data for address %h", test, a));
            end
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        compare_word($sformatf("%s @%h", test, a), expected, rdata);
    endtask

    task automatic check_after_reset();
        compare_flag("reset cmd_ready", 1'b1, cmd_ready);
        compare_flag("reset rdata_valid", 1'b0, rdata_valid);
    endtask

    // Known contents for every word the tests touch, last word for the wrap case
    task automatic fill_memory();
        mem_bus_pkg::addr_t a;
        for (int w = 0; w < FILL_WORDS; w++) begin
            a = mem_bus_pkg::addr_t'(w * `MAC_WORD_BYTES);
            do_write("fill", a, fill_pattern(a), '1);
        end
        a = mem_bus_pkg::addr_t'(MODEL_BYTES - `MAC_WORD_BYTES);
        do_write("fill", a, fill_pattern(a), '1);
    endtask

    task automatic aligned_full_writes();
        for (int w = 0; w < 8; w++) begin
            do_write("aligned full", mem_bus_pkg::addr_t'(w * 4), $urandom, '1);
        end
        for (int w = 0; w < 8; w++) begin
            do_read("aligned full", mem_bus_pkg::addr_t'(w * 4));
        end
    endtask

    task automatic partial_mask_writes();
        mem_bus_pkg::mask_t masks [6] = '{32'h0000_00FF, 32'h0000_FF00, 32'hFFFF_0000,
                                          32'h00FF_00FF, 32'h0F0F_0F0F, 32'h8000_0001};
        mem_bus_pkg::addr_t a;
        for (int i = 0; i < 6; i++) begin
            a = mem_bus_pkg::addr_t'((8 + i) * 4);
            do_write("partial mask", a, $urandom, masks[i]);
            do_read("partial mask", a);
        end
    endtask

    task automatic unaligned_accesses();
        mem_bus_pkg::mask_t masks [2] = '{32'hFFFF_FFFF, 32'h00FF_FF00};
        mem_bus_pkg::addr_t base;
        base = mem_bus_pkg::addr_t'(12 * 4);
        for (int off = 1; off < 4; off++) begin
            for (int m = 0; m < 2; m++) begin
                do_write("unaligned write", base + off, $urandom, masks[m]);
                // Both touched words, then every unaligned view of them
                do_read("unaligned lo word", base);
                do_read("unaligned hi word", base + 4);
                for (int r = 1; r < 4; r++) begin
                    do_read("unaligned read", base + r);
                end
            end
        end
        // Last word of RAM spills into word 0
        do_write("wrap write", mem_bus_pkg::addr_t'(MODEL_BYTES - 2), $urandom, '1);
        do_read("wrap read", mem_bus_pkg::addr_t'(MODEL_BYTES - 2));
    endtask

    task automatic random_traffic();
        mem_bus_pkg::addr_t a;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            a = mem_bus_pkg::addr_t'($urandom_range(0, 16 * 4 - 1));
            if ($urandom_range(0, 1) == 1) begin
                do_write("random write", a, $urandom, byte_mask(4'($urandom_range(0, 15))));
            end else begin
                do_read("random read", a);
            end
        end
    endtask

    // Hang guard sized from the planned request count
    initial begin
        #(WATCHDOG_NS);
        stop_run("Watchdog expired, the controller stopped making progress");
    end

    // Any failed sequencer assertion ends the run
    initial begin
        wait (i_mem_access_controller.i_access_sequencer.i_asserts.fail_count != 0);
        stop_run("A sequencer assertion failed");
    end

    initial begin
        rnd_seed  = 78;
        void'($urandom(rnd_seed));
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_start = 1'b0;
        op        = mem_ctrl_pkg::OP_READ;
        addr      = '0;
        wdata     = '0;
        wmask     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        check_after_reset();
        fill_memory();
        aligned_full_writes();
        partial_mask_writes();
        unaligned_accesses();
        random_traffic();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sim/mem_access_controller_asserts.sv
`timescale 1ns/10ps

module mem_access_controller_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     cmd_ready,
    input logic                     rdata_valid,
    input logic                     ram_start,
    input logic                     ram_ready,
    input mem_ctrl_pkg::seq_state_e state
);

    // Count of failed checks
    int fail_count = 0;

    // Response pulse only while a request is in flight
    a_valid_not_ready: assert property (@(posedge clk) disable iff (reset)
        !(rdata_valid && cmd_ready))
        else begin
            fail_count++;
            $error("rdata_valid and cmd_ready high in the same cycle");
        end

    // Idle sequencer leaves the RAM port quiet
    a_idle_no_start: assert property (@(posedge clk) disable iff (reset)
        !(state == mem_ctrl_pkg::ST_IDLE && ram_start))
        else begin
            fail_count++;
            $error("ram_start raised in ST_IDLE");
        end

    // Back-pressure from the RAM is honoured
    a_start_needs_ready: assert property (@(posedge clk) disable iff (reset)
        !(ram_start && !ram_ready))
        else begin
            fail_count++;
            $error("ram_start raised while ram_ready is low");
        end

    // Reset leaves the controller ready for a request
    a_ready_after_reset: assert property (@(posedge clk) reset |=> cmd_ready)
        else begin
            fail_count++;
            $error("cmd_ready low right after reset");
        end

endmodule

// File: hw/mem_access_controller.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module mem_access_controller #(
    parameter int DEPTH = `MAC_RAM_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_start,
    input  mem_ctrl_pkg::mem_op_e op,
    input  mem_bus_pkg::addr_t    addr,
    input  mem_bus_pkg::word_t    wdata,
    input  mem_bus_pkg::mask_t    wmask,
    output logic                  cmd_ready,
    output mem_bus_pkg::word_t    rdata,
    output logic                  rdata_valid
);

    // RAM command and return
    logic                   ram_start;
    logic                   ram_write;
    mem_bus_pkg::addr_t     ram_addr;
    mem_bus_pkg::word_t     ram_wdata;
    logic                   ram_ready;
    mem_bus_pkg::word_t     ram_rdata;
    logic                   ram_rdata_valid;

    // Sequencer to datapath
    mem_bus_pkg::byte_off_t offset;
    mem_bus_pkg::word_t     cap_wdata;
    mem_bus_pkg::mask_t     cap_wmask;
    mem_bus_pkg::word_t     saved_lo;
    mem_bus_pkg::word_t     saved_hi;

    // Datapath back to sequencer
    mem_bus_pkg::word_t     read_word;
    mem_bus_pkg::word_t     merged_lo;
    mem_bus_pkg::word_t     merged_hi;

    access_sequencer i_access_sequencer (
        .clk             (clk),
        .reset           (reset),
        .cmd_start       (cmd_start),
        .op              (op),
        .addr            (addr),
        .wdata           (wdata),
        .wmask           (wmask),
        .cmd_ready       (cmd_ready),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .ram_start       (ram_start),
        .ram_write       (ram_write),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_ready       (ram_ready),
        .ram_rdata       (ram_rdata),
        .ram_rdata_valid (ram_rdata_valid),
        .offset          (offset),
        .cap_wdata       (cap_wdata),
        .cap_wmask       (cap_wmask),
        .saved_lo        (saved_lo),
        .saved_hi        (saved_hi),
        .read_word       (read_word),
        .merged_lo       (merged_lo),
        .merged_hi       (merged_hi)
    );

    // Read joins saved low word with the live RAM return
    read_aligner i_read_aligner (
        .offset    (offset),
        .saved_lo  (saved_lo),
        .ram_rdata (ram_rdata),
        .read_word (read_word)
    );

    write_merger i_write_merger (
        .offset    (offset),
        .wdata     (cap_wdata),
        .wmask     (cap_wmask),
        .saved_lo  (saved_lo),
        .saved_hi  (saved_hi),
        .merged_lo (merged_lo),
        .merged_hi (merged_hi)
    );

    word_ram #(
        .DEPTH (DEPTH)
    ) i_word_ram (
        .clk             (clk),
        .reset           (reset),
        .ram_start       (ram_start),
        .ram_write       (ram_write),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_ready       (ram_ready),
        .ram_rdata       (ram_rdata),
        .ram_rdata_valid (ram_rdata_valid)
    );

endmodule

// File: hw/access_sequencer.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module access_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    // Requester side
    input  logic                    cmd_start,
    input  mem_ctrl_pkg::mem_op_e   op,
    input  mem_bus_pkg::addr_t      addr,
    input  mem_bus_pkg::word_t      wdata,
    input  mem_bus_pkg::mask_t      wmask,
    output logic                    cmd_ready,
    output mem_bus_pkg::word_t      rdata,
    output logic                    rdata_valid,
    // RAM side
    output logic                    ram_start,
    output logic                    ram_write,
    output mem_bus_pkg::addr_t      ram_addr,
    output mem_bus_pkg::word_t      ram_wdata,
    input  logic                    ram_ready,
    input  mem_bus_pkg::word_t      ram_rdata,
    input  logic                    ram_rdata_valid,
    // Datapath side
    output mem_bus_pkg::byte_off_t  offset,
    output mem_bus_pkg::word_t      cap_wdata,
    output mem_bus_pkg::mask_t      cap_wmask,
    output mem_bus_pkg::word_t      saved_lo,
    output mem_bus_pkg::word_t      saved_hi,
    input  mem_bus_pkg::word_t      read_word,
    input  mem_bus_pkg::word_t      merged_lo,
    input  mem_bus_pkg::word_t      merged_hi
);

    mem_ctrl_pkg::seq_state_e state;
    mem_ctrl_pkg::seq_state_e state_next;

    mem_ctrl_pkg::mem_op_e cap_op;
    mem_bus_pkg::addr_t    cap_addr;
    mem_bus_pkg::addr_t    addr_lo;
    mem_bus_pkg::addr_t    addr_hi;
    logic                  aligned;
    logic                  full_mask;
    logic                  issue_hi;

    assign offset    = mem_bus_pkg::byte_off_t'(cap_addr);
    assign aligned   = (offset == '0);
    assign full_mask = (cap_wmask == '1);

    // Word holding the request address and the word after it
    assign addr_lo = cap_addr & ~mem_bus_pkg::addr_t'(`MAC_WORD_BYTES - 1);
    assign addr_hi = addr_lo + mem_bus_pkg::addr_t'(`MAC_WORD_BYTES);

    assign cmd_ready = (state == mem_ctrl_pkg::ST_IDLE);

    // Final read return, aligned first word or unaligned second word
    assign rdata_valid = ram_rdata_valid &&
                         ((state == mem_ctrl_pkg::ST_READ_LO && aligned) ||
                          state == mem_ctrl_pkg::ST_READ_HI);
    assign rdata = rdata_valid ? read_word : '0;

    // States that put a command on the RAM port
    always_comb begin
        case (state)
            mem_ctrl_pkg::ST_ISSUE,
            mem_ctrl_pkg::ST_RMW_WRITE,
            mem_ctrl_pkg::ST_RMW_ISSUE_HI,
            mem_ctrl_pkg::ST_WRITE_LO,
            mem_ctrl_pkg::ST_WRITE_HI,
            mem_ctrl_pkg::ST_READ_ISSUE_HI: ram_start = ram_ready;
            default:                        ram_start = 1'b0;
        endcase
    end

    // Only a full aligned write goes out straight from ST_ISSUE
    always_comb begin
        ram_write = 1'b0;
        ram_wdata = '0;
        case (state)
            mem_ctrl_pkg::ST_ISSUE: begin
                if (cap_op == mem_ctrl_pkg::OP_WRITE && aligned && full_mask) begin
                    ram_write = 1'b1;
                    ram_wdata = cap_wdata;
                end
            end
            mem_ctrl_pkg::ST_RMW_WRITE,
            mem_ctrl_pkg::ST_WRITE_LO: begin
                ram_write = 1'b1;
                ram_wdata = merged_lo;
            end
            mem_ctrl_pkg::ST_WRITE_HI: begin
                ram_write = 1'b1;
                ram_wdata = merged_hi;
            end
            default: begin
                ram_write = 1'b0;
            end
        endcase
    end

    // Second-word accesses use the next word address
    assign issue_hi = (state == mem_ctrl_pkg::ST_RMW_ISSUE_HI) ||
                      (state == mem_ctrl_pkg::ST_WRITE_HI) ||
                      (state == mem_ctrl_pkg::ST_READ_ISSUE_HI);
    assign ram_addr = issue_hi ? addr_hi : addr_lo;

    always_comb begin
        state_next = state;
        case (state)
            mem_ctrl_pkg::ST_IDLE:
                if (cmd_start) state_next = mem_ctrl_pkg::ST_ISSUE;
            mem_ctrl_pkg::ST_ISSUE:
                if (ram_ready) begin
                    if (cap_op == mem_ctrl_pkg::OP_READ) begin
                        state_next = mem_ctrl_pkg::ST_READ_LO;
                    end else if (aligned && full_mask) begin
                        state_next = mem_ctrl_pkg::ST_END;
                    end else begin
                        state_next = mem_ctrl_pkg::ST_RMW_READ_LO;
                    end
                end
            mem_ctrl_pkg::ST_END:
                state_next = mem_ctrl_pkg::ST_IDLE;
            mem_ctrl_pkg::ST_RMW_READ_LO:
                if (ram_rdata_valid) begin
                    state_next = aligned ? mem_ctrl_pkg::ST_RMW_WRITE
                                         : mem_ctrl_pkg::ST_RMW_ISSUE_HI;
                end
            mem_ctrl_pkg::ST_RMW_WRITE:
                if (ram_ready) state_next = mem_ctrl_pkg::ST_END;
            mem_ctrl_pkg::ST_RMW_ISSUE_HI:
                if (ram_ready) state_next = mem_ctrl_pkg::ST_RMW_READ_HI;
            mem_ctrl_pkg::ST_RMW_READ_HI:
                if (ram_rdata_valid) state_next = mem_ctrl_pkg::ST_WRITE_LO;
            // Write-back phases step on RAM ready
            mem_ctrl_pkg::ST_WRITE_LO:
                if (ram_ready) state_next = mem_ctrl_pkg::ST_WRITE_HI;
            mem_ctrl_pkg::ST_WRITE_HI:
                if (ram_ready) state_next = mem_ctrl_pkg::ST_END;
            mem_ctrl_pkg::ST_READ_LO:
                if (ram_rdata_valid) begin
                    state_next = aligned ? mem_ctrl_pkg::ST_END
                                         : mem_ctrl_pkg::ST_READ_ISSUE_HI;
                end
            mem_ctrl_pkg::ST_READ_ISSUE_HI:
                if (ram_ready) state_next = mem_ctrl_pkg::ST_READ_HI;
            mem_ctrl_pkg::ST_READ_HI:
                if (ram_rdata_valid) state_next = mem_ctrl_pkg::ST_END;
            default:
                state_next = mem_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_ctrl_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request capture and saved RAM words
    always_ff @(posedge clk) begin
        if (cmd_start && cmd_ready) begin
            cap_op    <= op;
            cap_addr  <= addr;
            cap_wdata <= wdata;
            cap_wmask <= wmask;
        end
        // First returned word of any two-step access
        if (ram_rdata_valid && (state == mem_ctrl_pkg::ST_RMW_READ_LO ||
                                state == mem_ctrl_pkg::ST_READ_LO)) begin
            saved_lo <= ram_rdata;
        end
        if (ram_rdata_valid && state == mem_ctrl_pkg::ST_RMW_READ_HI) begin
            saved_hi <= ram_rdata;
        end
    end

endmodule

// File: hw/write_merger.sv
`timescale 1ns/10ps

module write_merger (
    input  mem_bus_pkg::byte_off_t offset,
    input  mem_bus_pkg::word_t     wdata,
    input  mem_bus_pkg::mask_t     wmask,
    input  mem_bus_pkg::word_t     saved_lo,
    input  mem_bus_pkg::word_t     saved_hi,
    output mem_bus_pkg::word_t     merged_lo,
    output mem_bus_pkg::word_t     merged_hi
);

    localparam int W = $bits(mem_bus_pkg::word_t);

    // Data and mask placed across two adjacent words
    logic [2*W-1:0] data_wide;
    logic [2*W-1:0] mask_wide;

    mem_bus_pkg::word_t data_lo;
    mem_bus_pkg::word_t data_hi;
    mem_bus_pkg::mask_t mask_lo;
    mem_bus_pkg::mask_t mask_hi;

    // Old bits where the mask is clear, new bits where it is set
    function automatic mem_bus_pkg::word_t merge_word(
        input mem_bus_pkg::word_t old_word,
        input mem_bus_pkg::word_t new_word,
        input mem_bus_pkg::mask_t mask
    );
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Move write data up to its byte lane
    // Bytes past the top of the low word spill into the high word
    assign data_wide = {{W{1'b0}}, wdata} << {offset, 3'b000};

    // Mask follows the same shift
    // Zeros shifted in keep the low bytes of saved_lo untouched
    assign mask_wide = {{W{1'b0}}, wmask} << {offset, 3'b000};

    // Split into the two RAM words
    assign data_lo = data_wide[W-1:0];
    assign data_hi = data_wide[2*W-1:W];
    assign mask_lo = mask_wide[W-1:0];
    assign mask_hi = mask_wide[2*W-1:W];

    // Word at the aligned address
    assign merged_lo = merge_word(saved_lo, data_lo, mask_lo);

    // Next word, unchanged for offset 0 since its mask is all zero
    assign merged_hi = merge_word(saved_hi, data_hi, mask_hi);

endmodule

// File: hw/read_aligner.sv
`timescale 1ns/10ps

module read_aligner (
    input  mem_bus_pkg::byte_off_t offset,
    input  mem_bus_pkg::word_t     saved_lo,
    input  mem_bus_pkg::word_t     ram_rdata,
    output mem_bus_pkg::word_t     read_word
);

    localparam int W = $bits(mem_bus_pkg::word_t);

    // Bytes to drop from the bottom of the joined pair
    logic [2:0]     shift_bytes;
    // Low word in the bottom half, high word on top
    logic [2*W-1:0] joined;
    logic [2*W-1:0] shifted;

    // Offset 1..3 drops that many bytes of saved_lo
    // Offset 0 drops all of saved_lo so the RAM word comes straight out
    assign shift_bytes = {1'b0, offset - 2'd1} + 3'd1;

    assign joined = {ram_rdata, saved_lo};

    // One byte shift for every offset
    assign shifted = joined >> {shift_bytes, 3'b000};

    // Little-endian result, byte at the request address in bits 7:0
    assign read_word = shifted[W-1:0];

endmodule

// File: hw/word_ram.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module word_ram #(
    parameter int DEPTH = `MAC_RAM_DEPTH
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ram_start,
    input  logic               ram_write,
    input  mem_bus_pkg::addr_t ram_addr,
    input  mem_bus_pkg::word_t ram_wdata,
    output logic               ram_ready,
    output mem_bus_pkg::word_t ram_rdata,
    output logic               ram_rdata_valid
);

    localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int BYTE_SH = $clog2(`MAC_WORD_BYTES);

    mem_bus_pkg::word_t mem [DEPTH];

    mem_bus_pkg::addr_t word_addr;
    logic [IDX_W-1:0]   idx;
    logic               accept;

    // Byte address down to word address, then wrap inside the array
    assign word_addr = ram_addr >> BYTE_SH;
    assign idx       = IDX_W'(word_addr % DEPTH);

    // Command taken only on the start and ready handshake
    assign accept = ram_start && ram_ready;

    // Control side
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_ready       <= 1'b0;
            ram_rdata_valid <= 1'b0;
        end else begin
            // This model never stalls once out of reset
            ram_ready       <= 1'b1;
            // Read data valid exactly one cycle after acceptance
            ram_rdata_valid <= accept && !ram_write;
        end
    end

    // Storage and read data register
    always_ff @(posedge clk) begin
        if (accept) begin
            if (ram_write) begin
                mem[idx] <= ram_wdata;
            end else begin
                ram_rdata <= mem[idx];
            end
        end
    end

endmodule

// File: hw/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // Request opcode from the requester
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Access sequencer states
    typedef enum logic [3:0] {
        ST_IDLE          = 4'd0,
        ST_ISSUE         = 4'd1,
        ST_END           = 4'd2,
        // Write that needs old data first
        ST_RMW_READ_LO   = 4'd3,
        ST_RMW_WRITE     = 4'd4,
        ST_RMW_ISSUE_HI  = 4'd5,
        ST_RMW_READ_HI   = 4'd6,
        // Unaligned write back of both words
        ST_WRITE_LO      = 4'd7,
        ST_WRITE_HI      = 4'd8,
        // Read path
        ST_READ_LO       = 4'd9,
        ST_READ_ISSUE_HI = 4'd10,
        ST_READ_HI       = 4'd11
    } seq_state_e;

endpackage

// File: hw/mem_bus_pkg.sv
`include "mem_access_defs.svh"

package mem_bus_pkg;

    // One RAM or requester data word
    typedef logic [`MAC_DATA_W-1:0] word_t;

    // Byte address as seen by the requester
    typedef logic [`MAC_ADDR_W-1:0] addr_t;

    // Write mask, one bit per data bit
    typedef logic [`MAC_DATA_W-1:0] mask_t;

    // Byte position inside a word, low address bits
    typedef logic [$clog2(`MAC_WORD_BYTES)-1:0] byte_off_t;

endpackage

// File: hw/mem_access_defs.svh
`ifndef MEM_ACCESS_DEFS_SVH
`define MEM_ACCESS_DEFS_SVH

// Data word width in bits
`define MAC_DATA_W 32

// Byte address width, the full requester address space
`define MAC_ADDR_W 32

// Bytes in one RAM word
`define MAC_WORD_BYTES 4

// Default RAM depth in words
// Addresses past the end wrap back to word 0
`define MAC_RAM_DEPTH 1024

`endif
